// ==== Makefile ====
# tool, flags, top module and file list
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := rv_core_tb
FILELIST := rv_core.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard verification/*.svh)
PASS_MSG := PASS: all tests

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// ==== logic/decode_ctrl.sv ====
// decode control, splits one instruction into fields, control bits and immediate
`timescale 1ns/1ps

module decode_ctrl
	import rv_pkg::*;
(
	input  logic [XLEN-1:0]       if_id_instr,
	input  logic [PC_W-1:0]       if_id_pc,
	output logic [REG_ADDR_W-1:0] rs1,
	output logic [REG_ADDR_W-1:0] rs2,
	output logic [REG_ADDR_W-1:0] rd,
	output logic                  reg_write,
	output logic                  alu_src_imm,
	output logic                  is_branch,
	output logic                  branch_ne,
	output alu_op_e               alu_op,
	output logic [XLEN-1:0]       immediate,
	output logic [PC_W-1:0]       id_pc
);

	opcode_e    opcode;
	logic [2:0] funct3;
	logic       funct7_alt;
	alu_op_e    funct_op;

	assign opcode     = opcode_e'(if_id_instr[OPCODE_W-1:0]);
	assign rd         = if_id_instr[RD_LSB +: REG_ADDR_W];
	assign funct3     = if_id_instr[FUNCT3_LSB +: 3];
	assign rs1        = if_id_instr[RS1_LSB +: REG_ADDR_W];
	assign rs2        = if_id_instr[RS2_LSB +: REG_ADDR_W];
	assign funct7_alt = if_id_instr[FUNCT7_ALT_BIT];
	assign id_pc      = if_id_pc;

	// shared by R and I formats
	always_comb begin
		case (funct3)
			FUNCT3_ADD: funct_op = ALU_ADD;
			FUNCT3_SLL: funct_op = ALU_SLL;
			FUNCT3_SLT: funct_op = ALU_SLT;
			FUNCT3_XOR: funct_op = ALU_XOR;
			FUNCT3_SRL: funct_op = ALU_SRL;
			FUNCT3_OR:  funct_op = ALU_OR;
			FUNCT3_AND: funct_op = ALU_AND;
			default:    funct_op = ALU_ADD;
		endcase
	end

	always_comb begin
		reg_write   = 1'b0;
		alu_src_imm = 1'b0;
		is_branch   = 1'b0;
		branch_ne   = 1'b0;
		alu_op      = ALU_ADD;
		case (opcode)
			OP_RTYPE: begin
				reg_write = (rd != '0);
				if (funct3 == FUNCT3_ADD && funct7_alt) begin
					alu_op = ALU_SUB;
				end else begin
					alu_op = funct_op;
				end
			end
			OP_ITYPE: begin
				reg_write   = (rd != '0);
				alu_src_imm = 1'b1;
				alu_op      = funct_op;
			end
			OP_BRANCH: begin
				// equality comes from the zero flag of the subtraction
				is_branch = (funct3 == FUNCT3_BEQ) || (funct3 == FUNCT3_BNE);
				branch_ne = (funct3 == FUNCT3_BNE);
				alu_op    = ALU_SUB;
			end
			default: begin
				reg_write = 1'b0;
			end
		endcase
	end

	always_comb begin
		if (opcode == OP_BRANCH) begin
			immediate = {{(XLEN-12){if_id_instr[31]}}, if_id_instr[7],
				if_id_instr[30:25], if_id_instr[11:8], 1'b0};
		end else begin
			immediate = {{(XLEN-12){if_id_instr[31]}}, if_id_instr[31:20]};
		end
	end

endmodule

// ==== logic/execute_stage.sv ====
// execute stage with ID/EX register, forwarding, ALU, branch decision and EX/WB
`timescale 1ns/1ps

module execute_stage
	import rv_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  fetch_stall,
	input  logic [REG_ADDR_W-1:0] rs1,
	input  logic [REG_ADDR_W-1:0] rs2,
	input  logic [REG_ADDR_W-1:0] rd,
	input  logic                  reg_write,
	input  logic                  alu_src_imm,
	input  logic                  is_branch,
	input  logic                  branch_ne,
	input  alu_op_e               alu_op,
	input  logic [XLEN-1:0]       immediate,
	input  logic [PC_W-1:0]       id_pc,
	input  logic [XLEN-1:0]       rs1_data,
	input  logic [XLEN-1:0]       rs2_data,
	output logic                  branch_taken,
	output logic [PC_W-1:0]       branch_target,
	output logic                  retire_valid,
	output logic [REG_ADDR_W-1:0] retire_rd,
	output logic [XLEN-1:0]       retire_data
);

	logic                  ex_reg_write, ex_alu_src_imm, ex_is_branch, ex_branch_ne;
	alu_op_e               ex_alu_op;
	logic [REG_ADDR_W-1:0] ex_rs1, ex_rs2, ex_rd;
	logic [XLEN-1:0]       ex_rs1_data, ex_rs2_data, ex_imm;
	logic [PC_W-1:0]       ex_pc;
	logic                  fwd_a, fwd_b, alu_zero;
	logic [XLEN-1:0]       op_a, op_b_reg, op_b, alu_result;
	logic                  wb_reg_write;
	logic [REG_ADDR_W-1:0] wb_rd;
	logic [XLEN-1:0]       wb_data;

	// --------------------------------------------------
	// ID/EX register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_reg_write   <= 1'b0;
			ex_alu_src_imm <= 1'b0;
			ex_is_branch   <= 1'b0;
			ex_branch_ne   <= 1'b0;
			ex_alu_op      <= ALU_ADD;
		end else if (!fetch_stall) begin
			// taken branch squashes the instruction behind it
			ex_reg_write   <= branch_taken ? 1'b0 : reg_write;
			ex_alu_src_imm <= branch_taken ? 1'b0 : alu_src_imm;
			ex_is_branch   <= branch_taken ? 1'b0 : is_branch;
			ex_branch_ne   <= branch_taken ? 1'b0 : branch_ne;
			ex_alu_op      <= branch_taken ? ALU_ADD : alu_op;
		end
	end

	always_ff @(posedge clk) begin
		if (!fetch_stall) begin
			ex_rs1      <= rs1;
			ex_rs2      <= rs2;
			ex_rd       <= rd;
			ex_rs1_data <= rs1_data;
			ex_rs2_data <= rs2_data;
			ex_imm      <= immediate;
			ex_pc       <= id_pc;
		end
	end

	// --------------------------------------------------
	// forwarding and ALU
	// --------------------------------------------------
	assign fwd_a    = wb_reg_write && (wb_rd != '0) && (wb_rd == ex_rs1);
	assign fwd_b    = wb_reg_write && (wb_rd != '0) && (wb_rd == ex_rs2);
	assign op_a     = fwd_a ? wb_data : ex_rs1_data;
	assign op_b_reg = fwd_b ? wb_data : ex_rs2_data;
	assign op_b     = ex_alu_src_imm ? ex_imm : op_b_reg;

	always_comb begin
		case (ex_alu_op)
			ALU_ADD: alu_result = op_a + op_b;
			ALU_SUB: alu_result = op_a - op_b;
			ALU_AND: alu_result = op_a & op_b;
			ALU_OR:  alu_result = op_a | op_b;
			ALU_XOR: alu_result = op_a ^ op_b;
			ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLL: alu_result = op_a << op_b[4:0];
			ALU_SRL: alu_result = op_a >> op_b[4:0];
			default: alu_result = '0;
		endcase
	end

	assign alu_zero      = (alu_result == '0);
	assign branch_taken  = ex_is_branch && (ex_branch_ne ? !alu_zero : alu_zero) && !fetch_stall;
	assign branch_target = ex_pc + ex_imm[PC_W-1:0];

	// --------------------------------------------------
	// EX/WB register and retirement
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_reg_write <= 1'b0;
		end else if (!fetch_stall) begin
			wb_reg_write <= ex_reg_write;
		end
	end

	always_ff @(posedge clk) begin
		if (!fetch_stall) begin
			wb_rd   <= ex_rd;
			wb_data <= alu_result;
		end
	end

	assign retire_valid = wb_reg_write && !fetch_stall;
	assign retire_rd    = wb_rd;
	assign retire_data  = wb_data;

	// a branch in execute carries no register write
	a_branch_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		ex_is_branch |-> !ex_reg_write);

endmodule

// ==== logic/fetch_stage.sv ====
// fetch stage holding the program counter and the IF/ID register
`timescale 1ns/1ps

module fetch_stage
	import rv_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               fetch_stall,
	input  logic [XLEN-1:0]    instr_rdata,
	input  logic               branch_taken,
	input  logic [PC_W-1:0]    branch_target,
	output logic [IADDR_W-1:0] instr_addr,
	output logic [XLEN-1:0]    if_id_instr,
	output logic [PC_W-1:0]    if_id_pc
);

	logic [PC_W-1:0] pc;
	logic [XLEN-1:0] swapped_instr;

	assign instr_addr = pc[PC_W-1:2];

	// memory words arrive big-endian
	assign swapped_instr = {instr_rdata[7:0], instr_rdata[15:8],
		instr_rdata[23:16], instr_rdata[31:24]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc          <= '0;
			if_id_instr <= NOP_INSTR;
		end else if (!fetch_stall) begin
			if (branch_taken) begin
				pc          <= branch_target;
				if_id_instr <= NOP_INSTR;
			end else begin
				pc          <= pc + PC_W'(4);
				if_id_instr <= swapped_instr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!fetch_stall) begin
			if_id_pc <= pc;
		end
	end

	// branch targets come from decoded immediates
	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		pc[1:0] == 2'b00);

endmodule

// ==== logic/reg_file.sv ====
// register file, 32 x 32 with x0 hardwired to zero and write-through reads
`timescale 1ns/1ps

module reg_file
	import rv_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] rs1,
	input  logic [REG_ADDR_W-1:0] rs2,
	input  logic                  wr_en,
	input  logic [REG_ADDR_W-1:0] wr_rd,
	input  logic [XLEN-1:0]       wr_data,
	output logic [XLEN-1:0]       rs1_data,
	output logic [XLEN-1:0]       rs2_data
);

	logic [XLEN-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_rd != '0) begin
			regs[wr_rd] <= wr_data;
		end
	end

	// same-cycle write is visible to decode
	assign rs1_data = (rs1 == '0) ? '0 :
		(wr_en && wr_rd == rs1) ? wr_data : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 :
		(wr_en && wr_rd == rs2) ? wr_data : regs[rs2];

	// decode drops writes to x0 before they reach write-back
	a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> wr_rd != '0);

endmodule

// ==== logic/rv_core.sv ====
// rv core top level, four-stage integer pipeline built from its stage blocks
`timescale 1ns/1ps

module rv_core
	import rv_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [XLEN-1:0]       instr_rdata,
	input  logic                  fetch_stall,
	output logic [IADDR_W-1:0]    instr_addr,
	output logic                  retire_valid,
	output logic [REG_ADDR_W-1:0] retire_rd,
	output logic [XLEN-1:0]       retire_data
);

	logic [XLEN-1:0]       if_id_instr;
	logic [PC_W-1:0]       if_id_pc, id_pc, branch_target;
	logic                  branch_taken;
	logic [REG_ADDR_W-1:0] rs1, rs2, rd;
	logic                  reg_write, alu_src_imm, is_branch, branch_ne;
	alu_op_e               alu_op;
	logic [XLEN-1:0]       immediate, rs1_data, rs2_data;

	fetch_stage u_fetch (
		.clk(clk), .rst_n(rst_n), .fetch_stall(fetch_stall),
		.instr_rdata(instr_rdata), .branch_taken(branch_taken),
		.branch_target(branch_target), .instr_addr(instr_addr),
		.if_id_instr(if_id_instr), .if_id_pc(if_id_pc)
	);

	decode_ctrl u_decode (
		.if_id_instr(if_id_instr), .if_id_pc(if_id_pc),
		.rs1(rs1), .rs2(rs2), .rd(rd), .reg_write(reg_write),
		.alu_src_imm(alu_src_imm), .is_branch(is_branch), .branch_ne(branch_ne),
		.alu_op(alu_op), .immediate(immediate), .id_pc(id_pc)
	);

	// write port fed by the retirement strobe
	reg_file u_regs (
		.clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2),
		.wr_en(retire_valid), .wr_rd(retire_rd), .wr_data(retire_data),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	execute_stage u_execute (
		.clk(clk), .rst_n(rst_n), .fetch_stall(fetch_stall),
		.rs1(rs1), .rs2(rs2), .rd(rd), .reg_write(reg_write),
		.alu_src_imm(alu_src_imm), .is_branch(is_branch), .branch_ne(branch_ne),
		.alu_op(alu_op), .immediate(immediate), .id_pc(id_pc),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
	);

endmodule

// ==== logic/rv_pkg.sv ====
// rv core shared package with widths, instruction encodings and field positions
package rv_pkg;

	localparam int XLEN       = 32;
	localparam int PC_W       = 9;
	localparam int IADDR_W    = PC_W - 2;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int OPCODE_W   = 7;

	// all-zero word, unknown opcode so it has no effect
	localparam logic [XLEN-1:0] NOP_INSTR = '0;

	// --------------------------------------------------
	// instruction field positions
	// --------------------------------------------------
	localparam int RD_LSB         = 7;
	localparam int FUNCT3_LSB     = 12;
	localparam int RS1_LSB        = 15;
	localparam int RS2_LSB        = 20;
	localparam int FUNCT7_ALT_BIT = 30;

	typedef enum logic [OPCODE_W-1:0] {
		OP_RTYPE  = 7'b0110011,
		OP_ITYPE  = 7'b0010011,
		OP_BRANCH = 7'b1100011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_SRL = 4'd7
	} alu_op_e;

	// add and sub share one code, funct7 bit 30 tells them apart
	localparam logic [2:0] FUNCT3_ADD = 3'b000;
	localparam logic [2:0] FUNCT3_SLL = 3'b001;
	localparam logic [2:0] FUNCT3_SLT = 3'b010;
	localparam logic [2:0] FUNCT3_XOR = 3'b100;
	localparam logic [2:0] FUNCT3_SRL = 3'b101;
	localparam logic [2:0] FUNCT3_OR  = 3'b110;
	localparam logic [2:0] FUNCT3_AND = 3'b111;
	localparam logic [2:0] FUNCT3_BEQ = 3'b000;
	localparam logic [2:0] FUNCT3_BNE = 3'b001;

endpackage

// ==== rv_core.f ====
+incdir+verification
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/decode_ctrl.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/rv_core.sv
verification/rv_core_tb.sv

// ==== verification/core_ref_model.svh ====
// rv core reference model with the LFSR, the program generator and an ISA model
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

localparam int MEM_WORDS = 128;

logic [31:0] lfsr_state = 32'hd00;
logic [31:0] prog_words [MEM_WORDS];
logic [4:0]  exp_rd [$];
logic [31:0] exp_data [$];

// taps for x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr_bit()};
	end
	return v;
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
	input logic [4:0] rd, input logic [4:0] rs1);
	return {imm, rs1, f3, rd, OP_ITYPE};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [2:0] f3,
	input logic [4:0] rs1, input logic [4:0] rs2);
	return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
endfunction

// returns the word index of the closing self-loop
function automatic int gen_program();
	int         len;
	int         kind;
	int         skip;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [2:0] f3;
	len = 60 + int'(rand_bits(5));
	for (int i = 0; i < len; i++) begin
		kind = int'(rand_bits(4));
		rd   = 5'(rand_bits(3));
		rs1  = 5'(rand_bits(3));
		rs2  = 5'(rand_bits(3));
		case ((kind < 8) ? kind : kind - 7)
			0, 1: f3 = FUNCT3_ADD;
			2: f3 = FUNCT3_AND;
			3: f3 = FUNCT3_OR;
			4: f3 = FUNCT3_XOR;
			5: f3 = FUNCT3_SLT;
			6: f3 = FUNCT3_SLL;
			default: f3 = FUNCT3_SRL;
		endcase
		if (kind < 8) begin
			prog_words[i] = {1'b0, kind == 1, 5'b0, rs2, rs1, f3, rd, OP_RTYPE};
		end else if (kind < 13) begin
			prog_words[i] = enc_i(12'(rand_bits(12)), f3, rd, rs1);
		end else begin
			// equal operands make BEQ taken and BNE not
			if (rand_bits(1) != 0) rs2 = rs1;
			skip = 1 + int'(rand_bits(2)) % 3;
			if (i + 1 + skip > len) skip = len - i - 1;
			f3 = (rand_bits(1) != 0) ? FUNCT3_BNE : FUNCT3_BEQ;
			prog_words[i] = enc_b(13'((skip + 1) * 4), f3, rs1, rs2);
		end
	end
	prog_words[len] = enc_b(13'd0, FUNCT3_BEQ, 5'd0, 5'd0);
	// words past the loop would retire a visible x1 value if ever executed
	for (int j = len + 1; j < MEM_WORDS; j++) begin
		prog_words[j] = enc_i({5'b10101, 7'(j)}, FUNCT3_ADD, 5'd1, 5'd0);
	end
	return len;
endfunction

// architectural model, walks the program up to the self-loop
function automatic void run_reference(input int loop_idx);
	logic [31:0] regs [32];
	logic [31:0] w, a, b, r;
	int          pc;
	exp_rd.delete();
	exp_data.delete();
	for (int i = 0; i < 32; i++) regs[i] = '0;
	pc = 0;
	while (pc < loop_idx) begin
		w = prog_words[pc];
		a = regs[w[19:15]];
		b = (w[6:0] == OP_ITYPE) ? {{20{w[31]}}, w[31:20]} : regs[w[24:20]];
		if (w[6:0] == OP_BRANCH) begin
			// funct3 bit 0 selects BNE
			if ((a == b) != w[12]) pc = pc + int'({w[31], w[7], w[30:25], w[11:8], 1'b0}) / 4;
			else pc = pc + 1;
		end else begin
			case (w[14:12])
				3'b000: r = (w[6:0] == OP_RTYPE && w[30]) ? a - b : a + b;
				3'b001: r = a << b[4:0];
				3'b010: r = 32'($signed(a) < $signed(b));
				3'b100: r = a ^ b;
				3'b101: r = a >> b[4:0];
				3'b110: r = a | b;
				default: r = a & b;
			endcase
			if (w[11:7] != 5'd0) begin
				regs[w[11:7]] = r;
				exp_rd.push_back(w[11:7]);
				exp_data.push_back(r);
			end
			pc = pc + 1;
		end
	end
endfunction

`endif

// ==== verification/rv_core_tb.sv ====
// testbench for the rv core, random programs checked against an ISA reference model
`timescale 1ns/1ps

module rv_core_tb
	import rv_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 4000;
	localparam int QUIET_CYCLES   = 50;
	localparam int NUM_PROGRAMS   = 3;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  fetch_stall;
	logic [XLEN-1:0]       instr_rdata;
	logic [IADDR_W-1:0]    instr_addr;
	logic                  retire_valid;
	logic [REG_ADDR_W-1:0] retire_rd;
	logic [XLEN-1:0]       retire_data;

	`include "core_ref_model.svh"

	logic [31:0] imem [MEM_WORDS];
	int          stall_mode;
	int          ret_count = 0;
	int          check_errors = 0;
	int          run_errors = 0;
	logic        run_ok;

	rv_core UUT (
		.clk(clk), .rst_n(rst_n), .instr_rdata(instr_rdata), .fetch_stall(fetch_stall),
		.instr_addr(instr_addr), .retire_valid(retire_valid), .retire_rd(retire_rd),
		.retire_data(retire_data)
	);

	// big-endian words, answered in the same cycle
	assign instr_rdata = imem[instr_addr];

	initial begin
		forever #4 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			check_errors++;
		end
	endtask

	// --------------------------------------------------
	// retirement compare
	// --------------------------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			ret_count <= 0;
		end else if (retire_valid) begin
			if (ret_count >= exp_rd.size()) begin
				$display("unexpected retirement to x%0d after the last expected one", retire_rd);
				check_errors++;
			end else begin
				check_value("retire_rd", 32'(retire_rd), 32'(exp_rd[ret_count]));
				check_value("retire_data", retire_data, exp_data[ret_count]);
			end
			ret_count <= ret_count + 1;
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	task automatic step_cycle();
		@(negedge clk);
		if (stall_mode == 0) fetch_stall = 1'b0;
		else if (stall_mode == 1) fetch_stall = (rand_bits(3) == 0);
		else fetch_stall = (rand_bits(1) != 0);
	endtask

	task automatic run_program(input int mode, output logic ok);
		int loop_idx;
		int cycles;
		rst_n       = 1'b0;
		fetch_stall = 1'b0;
		stall_mode  = mode;
		loop_idx    = gen_program();
		for (int j = 0; j < MEM_WORDS; j++) begin
			imem[j] = {prog_words[j][7:0], prog_words[j][15:8],
				prog_words[j][23:16], prog_words[j][31:24]};
		end
		run_reference(loop_idx);
		repeat (8) @(negedge clk);
		rst_n  = 1'b1;
		cycles = 0;
		while (ret_count < exp_rd.size() && cycles < TIMEOUT_CYCLES) begin
			step_cycle();
			cycles++;
		end
		ok = (ret_count >= exp_rd.size());
		if (!ok) begin
			$display("timeout: program %0d retired only %0d of %0d instructions",
				mode, ret_count, exp_rd.size());
		end else begin
			// core spins on the self-loop, nothing more may retire
			repeat (QUIET_CYCLES) step_cycle();
		end
	endtask

	initial begin
		rst_n       = 1'b0;
		fetch_stall = 1'b0;
		stall_mode  = 0;
		for (int p = 0; p < NUM_PROGRAMS; p++) begin
			run_program(p, run_ok);
			if (!run_ok) begin
				run_errors++;
				break;
			end
		end
		$display("errors: %0d check, %0d run", check_errors, run_errors);
		if (check_errors == 0 && run_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
